/* hw/alu_pkg.sv */
/*
 * ALU package for the integer execute lane.
 * Holds the data widths, the instruction opcode encoding
 * and the internal ALU operation codes.
 */
package alu_pkg;

    localparam int DATA_W  = 32;  // Operand and result width.
    localparam int IMM_W   = 16;  // Instruction immediate width.
    localparam int SHAMT_W = 5;   // Shift amount width.

    // Issue opcodes; codes not listed here are illegal.
    typedef enum logic [5:0] {
        NOP    = 6'h00,
        ADD    = 6'h01,
        ADDI   = 6'h02,
        ADDU   = 6'h03,
        ADDIU  = 6'h04,
        SUB    = 6'h05,
        SUBU   = 6'h06,
        MFHI   = 6'h07,
        MTHI   = 6'h08,
        MFLO   = 6'h09,
        MTLO   = 6'h0a,
        AND_OP = 6'h0b,
        ANDI   = 6'h0c,
        OR_OP  = 6'h0d,
        ORI    = 6'h0e,
        XOR_OP = 6'h0f,
        XORI   = 6'h10,
        NOR_OP = 6'h11,
        SLL    = 6'h12,
        SLLV   = 6'h13,
        SRL    = 6'h14,
        SRLV   = 6'h15,
        SRA    = 6'h16,
        SRAV   = 6'h17,
        SLT    = 6'h18,
        SLTI   = 6'h19,
        SLTU   = 6'h1a,
        SLTIU  = 6'h1b,
        LUI    = 6'h1c
    } opcode_e;

    // Operations the ALU datapath knows about.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_NOR  = 4'h5,
        ALU_SLL  = 4'h6,
        ALU_SRL  = 4'h7,
        ALU_SRA  = 4'h8,
        ALU_SLT  = 4'h9,
        ALU_SLTU = 4'ha,
        ALU_LUI  = 4'hb,
        ALU_PASS = 4'hc
    } alu_op_e;

endpackage

/* hw/issue_decode.sv */
/*
 * Issue decode stage.
 * Registers the issue packet and maps the opcode onto an ALU
 * operation, selected operands and the flag check enables.
 */
module issue_decode (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         valid_i,
    input  alu_pkg::opcode_e             opcode_i,
    input  logic [alu_pkg::DATA_W-1:0]   data1_i,
    input  logic [alu_pkg::DATA_W-1:0]   data2_i,
    input  logic [alu_pkg::IMM_W-1:0]    immd_i,
    output logic                         valid_o,
    output alu_pkg::alu_op_e             op_o,
    output logic [alu_pkg::DATA_W-1:0]   opa_o,
    output logic [alu_pkg::DATA_W-1:0]   opb_o,
    output logic [alu_pkg::SHAMT_W-1:0]  shamt_o,
    output logic                         ovf_en_o,
    output logic                         illegal_o,
    output logic                         nop_o
);
    import alu_pkg::*;

    logic [DATA_W-1:0]  imm_sext;
    logic [DATA_W-1:0]  imm_zext;
    alu_op_e            op_d;
    logic [DATA_W-1:0]  opa_d;
    logic [DATA_W-1:0]  opb_d;
    logic [SHAMT_W-1:0] shamt_d;
    logic               ovf_en_d;
    logic               illegal_d;
    logic               nop_d;

    assign imm_sext = {{(DATA_W-IMM_W){immd_i[IMM_W-1]}}, immd_i};
    assign imm_zext = {{(DATA_W-IMM_W){1'b0}}, immd_i};

    always_comb begin
        op_d      = ALU_PASS;
        opa_d     = data1_i;
        opb_d     = data2_i;
        shamt_d   = immd_i[SHAMT_W-1:0];  // Immediate shift amount by default.
        ovf_en_d  = 1'b0;
        illegal_d = 1'b0;
        nop_d     = 1'b0;
        case (opcode_i)
            NOP:                    nop_d = 1'b1;
            ADD, SUB:               begin
                op_d     = (opcode_i == ADD) ? ALU_ADD : ALU_SUB;
                ovf_en_d = 1'b1;
            end
            ADDI:                   begin
                op_d     = ALU_ADD;
                opb_d    = imm_sext;
                ovf_en_d = 1'b1;
            end
            ADDU:                   op_d = ALU_ADD;
            ADDIU:                  begin
                op_d  = ALU_ADD;
                opb_d = imm_sext;
            end
            SUBU:                   op_d = ALU_SUB;
            MFHI, MTHI, MFLO, MTLO: op_d = ALU_PASS;  // Forward operand A.
            AND_OP:                 op_d = ALU_AND;
            OR_OP:                  op_d = ALU_OR;
            XOR_OP:                 op_d = ALU_XOR;
            NOR_OP:                 op_d = ALU_NOR;
            ANDI, ORI, XORI:        begin
                op_d  = (opcode_i == ANDI) ? ALU_AND : (opcode_i == ORI) ? ALU_OR : ALU_XOR;
                opb_d = imm_zext;
            end
            SLL:                    op_d = ALU_SLL;
            SRL:                    op_d = ALU_SRL;
            SRA:                    op_d = ALU_SRA;
            SLLV, SRLV, SRAV:       begin
                op_d    = (opcode_i == SLLV) ? ALU_SLL : (opcode_i == SRLV) ? ALU_SRL : ALU_SRA;
                opa_d   = data2_i;                // Value to shift comes from data2.
                shamt_d = data1_i[SHAMT_W-1:0];
            end
            SLT:                    op_d = ALU_SLT;
            SLTU:                   op_d = ALU_SLTU;
            SLTI, SLTIU:            begin
                op_d  = (opcode_i == SLTI) ? ALU_SLT : ALU_SLTU;
                opb_d = (opcode_i == SLTI) ? imm_sext : imm_zext;
            end
            LUI:                    begin
                op_d  = ALU_LUI;
                opb_d = imm_zext;
            end
            default:                illegal_d = 1'b1;  // Unknown encoding.
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o   <= 1'b0;
            ovf_en_o  <= 1'b0;
            illegal_o <= 1'b0;
            nop_o     <= 1'b0;
        end else begin
            valid_o   <= valid_i;
            ovf_en_o  <= ovf_en_d;
            illegal_o <= illegal_d;
            nop_o     <= nop_d;
        end
    end

    // Operand payload is only loaded for a valid packet.
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            op_o    <= op_d;
            opa_o   <= opa_d;
            opb_o   <= opb_d;
            shamt_o <= shamt_d;
        end
    end

    a_opcode_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i |-> !$isunknown(opcode_i));

endmodule

/* hw/simple_alu.sv */
/*
 * Combinational ALU of the execute lane.
 * One shared adder serves add, subtract and both compares;
 * signed overflow is flagged for add and subtract.
 */
module simple_alu (
    input  alu_pkg::alu_op_e             op_i,
    input  logic [alu_pkg::DATA_W-1:0]   opa_i,
    input  logic [alu_pkg::DATA_W-1:0]   opb_i,
    input  logic [alu_pkg::SHAMT_W-1:0]  shamt_i,
    output logic [alu_pkg::DATA_W-1:0]   result_o,
    output logic                         overflow_o
);
    import alu_pkg::*;

    logic              sub_mode;
    logic [DATA_W-1:0] b_eff;
    logic [DATA_W:0]   sum_full;
    logic [DATA_W-1:0] sum;
    logic              carry_out;
    logic              ovf_raw;
    logic              lt_signed;
    logic              lt_unsigned;
    logic [DATA_W-1:0] shl;
    logic [DATA_W-1:0] shr_log;
    logic [DATA_W-1:0] shr_ari;
    logic [DATA_W-1:0] lui_val;

    // Compares reuse the subtractor.
    assign sub_mode = (op_i == ALU_SUB) || (op_i == ALU_SLT) || (op_i == ALU_SLTU);

    // Two's complement subtract as A + ~B + 1.
    assign b_eff     = sub_mode ? ~opb_i : opb_i;
    assign sum_full  = {1'b0, opa_i} + {1'b0, b_eff} + {{DATA_W{1'b0}}, sub_mode};
    assign sum       = sum_full[DATA_W-1:0];
    assign carry_out = sum_full[DATA_W];

    // Same input signs, result sign flipped.
    assign ovf_raw = (opa_i[DATA_W-1] == b_eff[DATA_W-1]) &&
                     (sum[DATA_W-1] != opa_i[DATA_W-1]);

    // Signed less-than is the difference sign corrected by overflow.
    assign lt_signed   = sum[DATA_W-1] ^ ovf_raw;
    // No carry out of A + ~B + 1 means A < B unsigned.
    assign lt_unsigned = ~carry_out;

    assign shl     = opa_i << shamt_i;
    assign shr_log = opa_i >> shamt_i;
    assign shr_ari = DATA_W'($signed(opa_i) >>> shamt_i);  // Sign bit fills from the left.

    assign lui_val = {opb_i[IMM_W-1:0], {(DATA_W-IMM_W){1'b0}}};

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = sum;
            ALU_SUB:  result_o = sum;
            ALU_AND:  result_o = opa_i & opb_i;
            ALU_OR:   result_o = opa_i | opb_i;
            ALU_XOR:  result_o = opa_i ^ opb_i;
            ALU_NOR:  result_o = ~(opa_i | opb_i);
            ALU_SLL:  result_o = shl;
            ALU_SRL:  result_o = shr_log;
            ALU_SRA:  result_o = shr_ari;
            ALU_SLT:  result_o = {{(DATA_W-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(DATA_W-1){1'b0}}, lt_unsigned};
            ALU_LUI:  result_o = lui_val;
            ALU_PASS: result_o = opa_i;       // HI/LO moves and fallback.
            default:  result_o = opa_i;
        endcase
    end

    // Only arithmetic ops can report overflow.
    assign overflow_o = ovf_raw && ((op_i == ALU_ADD) || (op_i == ALU_SUB));

endmodule

/* hw/exec_result.sv */
/*
 * Result stage of the execute lane.
 * Registers the ALU result and forms the executed and
 * exception flags for each packet.
 */
module exec_result (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        valid_i,
    input  logic [alu_pkg::DATA_W-1:0]  result_i,
    input  logic                        overflow_i,
    input  logic                        ovf_en_i,
    input  logic                        illegal_i,
    input  logic                        nop_i,
    output logic                        valid_o,
    output logic [alu_pkg::DATA_W-1:0]  result_o,
    output logic                        executed_o,
    output logic                        exception_o
);
    import alu_pkg::*;

    logic              no_result;
    logic              executed_d;
    logic              exception_d;
    logic [DATA_W-1:0] result_d;

    assign no_result = nop_i || illegal_i;

    assign executed_d  = valid_i && !no_result;
    assign exception_d = valid_i && (illegal_i || (overflow_i && ovf_en_i));

    // NOP and illegal packets return zero.
    assign result_d = no_result ? {DATA_W{1'b0}} : result_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o     <= 1'b0;
            executed_o  <= 1'b0;
            exception_o <= 1'b0;
        end else begin
            valid_o     <= valid_i;       // One-cycle pulse.
            executed_o  <= executed_d;
            exception_o <= exception_d;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= {DATA_W{1'b0}};
        end else if (valid_i) begin
            result_o <= result_d;         // Held between packets.
        end
    end

    // A packet is at most one of NOP, illegal or trapping arithmetic.
    a_flags_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i |-> $onehot0({nop_i, illegal_i, ovf_en_i}));

endmodule

/* hw/exec_lane_top.sv */
/*
 * Integer execute lane top level.
 * Decode, ALU and result stages in a two-cycle pipeline.
 */
module exec_lane_top (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        valid_i,
    input  alu_pkg::opcode_e            opcode_i,
    input  logic [alu_pkg::DATA_W-1:0]  data1_i,
    input  logic [alu_pkg::DATA_W-1:0]  data2_i,
    input  logic [alu_pkg::IMM_W-1:0]   immd_i,
    output logic                        valid_o,
    output logic [alu_pkg::DATA_W-1:0]  result_o,
    output logic                        executed_o,
    output logic                        exception_o
);
    import alu_pkg::*;

    logic               valid_q;
    alu_op_e            op_q;
    logic [DATA_W-1:0]  opa_q;
    logic [DATA_W-1:0]  opb_q;
    logic [SHAMT_W-1:0] shamt_q;
    logic               ovf_en_q;
    logic               illegal_q;
    logic               nop_q;
    logic [DATA_W-1:0]  alu_result;
    logic               alu_overflow;

    issue_decode u_decode (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .valid_i   (valid_i),
        .opcode_i  (opcode_i),
        .data1_i   (data1_i),
        .data2_i   (data2_i),
        .immd_i    (immd_i),
        .valid_o   (valid_q),
        .op_o      (op_q),
        .opa_o     (opa_q),
        .opb_o     (opb_q),
        .shamt_o   (shamt_q),
        .ovf_en_o  (ovf_en_q),
        .illegal_o (illegal_q),
        .nop_o     (nop_q)
    );

    simple_alu u_alu (
        .op_i       (op_q),
        .opa_i      (opa_q),
        .opb_i      (opb_q),
        .shamt_i    (shamt_q),
        .result_o   (alu_result),
        .overflow_o (alu_overflow)
    );

    exec_result u_result (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .valid_i     (valid_q),
        .result_i    (alu_result),
        .overflow_i  (alu_overflow),
        .ovf_en_i    (ovf_en_q),
        .illegal_i   (illegal_q),
        .nop_i       (nop_q),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .executed_o  (executed_o),
        .exception_o (exception_o)
    );

endmodule

/* sim/exec_lane_checker.sv */
/*
 * Checker for the execute lane.
 * Queues the expected result of each issued packet, pops one
 * on every valid_o pulse and compares value, flags and latency.
 */
module exec_lane_checker (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        push_i,
    input  logic [alu_pkg::DATA_W-1:0]  exp_result_i,
    input  logic                        exp_executed_i,
    input  logic                        exp_exception_i,
    input  logic                        valid_i,
    input  logic [alu_pkg::DATA_W-1:0]  result_i,
    input  logic                        executed_i,
    input  logic                        exception_i,
    output int                          checked_o,
    output int                          errors_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import alu_pkg::*;

    localparam int LATENCY = 2;  // Edges from issue sample to result.

    logic [DATA_W-1:0] q_result[$];
    logic              q_executed[$];
    logic              q_exception[$];
    int                q_cycle[$];
    logic [DATA_W-1:0] want_result;
    logic              want_executed;
    logic              want_exception;
    int                want_cycle;
    logic              bad;
    int                cycle = 0;
    int                checked = 0;
    int                errors = 0;

    assign checked_o = checked;
    assign errors_o  = errors;

    always @(posedge clk_i) begin
        cycle++;
        if (arst_n_i && valid_i) begin
            if (q_result.size() == 0) begin
                $display("[%0t] Result pulse seen with no packet outstanding", $time);
                errors++;
            end else begin
                want_result    = q_result.pop_front();
                want_executed  = q_executed.pop_front();
                want_exception = q_exception.pop_front();
                want_cycle     = q_cycle.pop_front();
                bad            = 1'b0;
                if (cycle != want_cycle + LATENCY) begin
                    $display("[%0t] Result came at cycle %0d instead of cycle %0d",
                             $time, cycle, want_cycle + LATENCY);
                    bad = 1'b1;
                end
                if (result_i !== want_result) begin
                    $display("ERR t=%0t result_o expected %h actual %h",
                             $time, want_result, result_i);
                    bad = 1'b1;
                end
                if (executed_i !== want_executed) begin
                    $display("ERR t=%0t executed_o expected %b actual %b",
                             $time, want_executed, executed_i);
                    bad = 1'b1;
                end
                if (exception_i !== want_exception) begin
                    $display("ERR t=%0t exception_o expected %b actual %b",
                             $time, want_exception, exception_i);
                    bad = 1'b1;
                end
                checked++;
                if (bad) begin
                    errors++;
                end
                $display("test %0d: result %h executed %b exception %b  %s",
                         checked, result_i, executed_i, exception_i, bad ? "FAIL" : "ok");
            end
        end
        // New expectation sampled on the same edge as the DUT input.
        if (arst_n_i && push_i) begin
            q_result.push_back(exp_result_i);
            q_executed.push_back(exp_executed_i);
            q_exception.push_back(exp_exception_i);
            q_cycle.push_back(cycle);
        end
    end

endmodule

/* sim/tb_exec_lane.sv */
/*
 * Testbench for the integer execute lane.
 * Applies a directed vector table and a random tail checked
 * against a reference model of the ALU rules.
 */
module tb_exec_lane;
    timeunit 1ns;
    timeprecision 100ps;
    import alu_pkg::*;

    localparam int N_RANDOM    = 40;
    localparam int DRAIN_LIMIT = 100;

    logic              clk;
    logic              arst_n;
    logic              valid;
    opcode_e           opcode;
    logic [DATA_W-1:0] data1;
    logic [DATA_W-1:0] data2;
    logic [IMM_W-1:0]  immd;
    logic              dut_valid;
    logic [DATA_W-1:0] dut_result;
    logic              dut_executed;
    logic              dut_exception;
    logic              exp_push;
    logic [DATA_W-1:0] exp_result;
    logic              exp_executed;
    logic              exp_exception;
    int                checked_cnt;
    int                error_cnt;

    // Directed vector table.
    logic [5:0]        tab_code[$];
    logic [DATA_W-1:0] tab_d1[$];
    logic [DATA_W-1:0] tab_d2[$];
    logic [IMM_W-1:0]  tab_imm[$];
    logic [DATA_W-1:0] tab_res[$];
    logic              tab_ex[$];
    logic              tab_exc[$];

    logic [31:0]       rng_state;
    logic [5:0]        r_code;
    logic [DATA_W-1:0] r_d1;
    logic [DATA_W-1:0] r_d2;
    logic [IMM_W-1:0]  r_imm;
    logic [DATA_W+1:0] r_exp;
    int                n_packets;
    int                wait_cnt;
    logic              timed_out;

    exec_lane_top u_exec_lane_top (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .valid_i     (valid),
        .opcode_i    (opcode),
        .data1_i     (data1),
        .data2_i     (data2),
        .immd_i      (immd),
        .valid_o     (dut_valid),
        .result_o    (dut_result),
        .executed_o  (dut_executed),
        .exception_o (dut_exception)
    );

    exec_lane_checker u_checker (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .push_i          (exp_push),
        .exp_result_i    (exp_result),
        .exp_executed_i  (exp_executed),
        .exp_exception_i (exp_exception),
        .valid_i         (dut_valid),
        .result_i        (dut_result),
        .executed_i      (dut_executed),
        .exception_i     (dut_exception),
        .checked_o       (checked_cnt),
        .errors_o        (error_cnt)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;  // 4 ns period.

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Returns {exception, executed, result} for one packet.
    function automatic logic [DATA_W+1:0] reference_result(input logic [5:0] code,
            input logic [31:0] d1, input logic [31:0] d2, input logic [15:0] imm);
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] res;
        logic        ovf;
        logic        ex;
        logic        exc;
        sx  = {{16{imm[15]}}, imm};
        zx  = {16'h0000, imm};
        res = 32'h0;
        ovf = 1'b0;
        ex  = 1'b1;
        exc = 1'b0;
        case (code)
            NOP:                    ex = 1'b0;
            ADD, ADDU:              begin
                res = d1 + d2;
                ovf = (d1[31] == d2[31]) && (res[31] != d1[31]);
            end
            ADDI, ADDIU:            begin
                res = d1 + sx;
                ovf = (d1[31] == sx[31]) && (res[31] != d1[31]);
            end
            SUB, SUBU:              begin
                res = d1 - d2;
                ovf = (d1[31] != d2[31]) && (res[31] != d1[31]);
            end
            MFHI, MTHI, MFLO, MTLO: res = d1;
            AND_OP:                 res = d1 & d2;
            OR_OP:                  res = d1 | d2;
            XOR_OP:                 res = d1 ^ d2;
            NOR_OP:                 res = ~(d1 | d2);
            ANDI:                   res = d1 & zx;
            ORI:                    res = d1 | zx;
            XORI:                   res = d1 ^ zx;
            SLL:                    res = d1 << imm[4:0];
            SRL:                    res = d1 >> imm[4:0];
            SRA:                    res = $signed(d1) >>> imm[4:0];
            SLLV:                   res = d2 << d1[4:0];
            SRLV:                   res = d2 >> d1[4:0];
            SRAV:                   res = $signed(d2) >>> d1[4:0];
            SLT:                    res = {31'h0, $signed(d1) < $signed(d2)};
            SLTI:                   res = {31'h0, $signed(d1) < $signed(sx)};
            SLTU:                   res = {31'h0, d1 < d2};
            SLTIU:                  res = {31'h0, d1 < zx};
            LUI:                    res = {imm, 16'h0000};
            default:                begin
                ex  = 1'b0;
                exc = 1'b1;
            end
        endcase
        if ((code == ADD) || (code == ADDI) || (code == SUB)) begin
            exc = ovf;  // Only the trapping forms raise it.
        end
        return {exc, ex, res};
    endfunction

    task automatic add_vector(input logic [5:0] code, input logic [31:0] d1,
            input logic [31:0] d2, input logic [15:0] imm, input logic [31:0] res,
            input logic ex, input logic exc);
        tab_code.push_back(code);
        tab_d1.push_back(d1);
        tab_d2.push_back(d2);
        tab_imm.push_back(imm);
        tab_res.push_back(res);
        tab_ex.push_back(ex);
        tab_exc.push_back(exc);
    endtask

    task automatic drive_packet(input logic [5:0] code, input logic [31:0] d1,
            input logic [31:0] d2, input logic [15:0] imm, input logic [31:0] res,
            input logic ex, input logic exc);
        @(posedge clk);
        valid         <= 1'b1;
        opcode        <= opcode_e'(code);
        data1         <= d1;
        data2         <= d2;
        immd          <= imm;
        exp_push      <= 1'b1;
        exp_result    <= res;
        exp_executed  <= ex;
        exp_exception <= exc;
        n_packets++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        valid    <= 1'b0;
        exp_push <= 1'b0;
    endtask

    initial begin
        arst_n        = 1'b0;
        valid         = 1'b0;
        opcode        = NOP;
        data1         = '0;
        data2         = '0;
        immd          = '0;
        exp_push      = 1'b0;
        exp_result    = '0;
        exp_executed  = 1'b0;
        exp_exception = 1'b0;
        n_packets     = 0;
        rng_state     = 32'd29658;

        add_vector(ADD,    32'h00000005, 32'h00000007, 16'h0000, 32'h0000000c, 1, 0);
        add_vector(ADD,    32'h7fffffff, 32'h00000001, 16'h0000, 32'h80000000, 1, 1);
        add_vector(ADDU,   32'h7fffffff, 32'h00000001, 16'h0000, 32'h80000000, 1, 0);
        add_vector(ADDI,   32'h00000010, 32'h00000000, 16'hffff, 32'h0000000f, 1, 0);
        add_vector(ADDI,   32'h7ffffff0, 32'h00000000, 16'h0010, 32'h80000000, 1, 1);
        add_vector(ADDIU,  32'h7ffffff0, 32'h00000000, 16'h0010, 32'h80000000, 1, 0);
        add_vector(SUB,    32'h00000010, 32'h00000003, 16'h0000, 32'h0000000d, 1, 0);
        add_vector(SUB,    32'h80000000, 32'h00000001, 16'h0000, 32'h7fffffff, 1, 1);
        add_vector(SUBU,   32'h80000000, 32'h00000001, 16'h0000, 32'h7fffffff, 1, 0);
        add_vector(SUBU,   32'h00000000, 32'h00000001, 16'h0000, 32'hffffffff, 1, 0);
        add_vector(MFHI,   32'h12345678, 32'h9abcdef0, 16'h0000, 32'h12345678, 1, 0);
        add_vector(MTLO,   32'hcafef00d, 32'h00000000, 16'h0000, 32'hcafef00d, 1, 0);
        add_vector(AND_OP, 32'hf0f0ff00, 32'h0ff0f0f0, 16'h0000, 32'h00f0f000, 1, 0);
        add_vector(OR_OP,  32'hf0f00000, 32'h0000000f, 16'h0000, 32'hf0f0000f, 1, 0);
        add_vector(XOR_OP, 32'hffff0000, 32'hff00ff00, 16'h0000, 32'h00ffff00, 1, 0);
        add_vector(NOR_OP, 32'hf0f0f0f0, 32'h0f0f0000, 16'h0000, 32'h00000f0f, 1, 0);
        add_vector(ANDI,   32'hffffffff, 32'h00000000, 16'h8001, 32'h00008001, 1, 0);
        add_vector(ORI,    32'h12340000, 32'h00000000, 16'hffff, 32'h1234ffff, 1, 0);
        add_vector(XORI,   32'hffffffff, 32'h00000000, 16'h8000, 32'hffff7fff, 1, 0);
        add_vector(SLL,    32'h00000001, 32'h00000000, 16'h001f, 32'h80000000, 1, 0);
        add_vector(SLL,    32'h0000000f, 32'h00000000, 16'h0024, 32'h000000f0, 1, 0);
        add_vector(SRL,    32'h80000000, 32'h00000000, 16'h0004, 32'h08000000, 1, 0);
        add_vector(SRA,    32'h80000000, 32'h00000000, 16'h0004, 32'hf8000000, 1, 0);
        add_vector(SLLV,   32'h00000003, 32'h00000011, 16'h0000, 32'h00000088, 1, 0);
        add_vector(SRLV,   32'h00000024, 32'hf0000000, 16'h0000, 32'h0f000000, 1, 0);
        add_vector(SRAV,   32'h00000008, 32'h80001000, 16'h0000, 32'hff800010, 1, 0);
        add_vector(SLT,    32'hffffffff, 32'h00000001, 16'h0000, 32'h00000001, 1, 0);
        add_vector(SLT,    32'h80000000, 32'h7fffffff, 16'h0000, 32'h00000001, 1, 0);
        add_vector(SLTU,   32'hffffffff, 32'h00000001, 16'h0000, 32'h00000000, 1, 0);
        add_vector(SLTI,   32'hfffffffe, 32'h00000000, 16'hffff, 32'h00000001, 1, 0);
        add_vector(SLTIU,  32'h00000005, 32'h00000000, 16'hffff, 32'h00000001, 1, 0);
        add_vector(LUI,    32'h00000000, 32'h00000000, 16'habcd, 32'habcd0000, 1, 0);
        add_vector(NOP,    32'h11111111, 32'h22222222, 16'h3333, 32'h00000000, 0, 0);
        add_vector(6'h3f,  32'h55555555, 32'h00000000, 16'h0000, 32'h00000000, 0, 1);
        add_vector(6'h1d,  32'h00000001, 32'h00000002, 16'h0003, 32'h00000000, 0, 1);

        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) idle_cycle();

        // Table packets go back to back.
        for (int i = 0; i < tab_code.size(); i++) begin
            drive_packet(tab_code[i], tab_d1[i], tab_d2[i], tab_imm[i],
                         tab_res[i], tab_ex[i], tab_exc[i]);
        end
        idle_cycle();

        for (int i = 0; i < N_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            r_code    = {1'b0, rng_state[4:0]};  // Upper codes are illegal.
            if (rng_state[31:29] == 3'b000) begin
                idle_cycle();
            end
            rng_state = xorshift32(rng_state);
            r_d1      = rng_state;
            rng_state = xorshift32(rng_state);
            r_d2      = rng_state;
            rng_state = xorshift32(rng_state);
            r_imm     = rng_state[15:0];
            r_exp     = reference_result(r_code, r_d1, r_d2, r_imm);
            drive_packet(r_code, r_d1, r_d2, r_imm, r_exp[DATA_W-1:0],
                         r_exp[DATA_W], r_exp[DATA_W+1]);
        end
        idle_cycle();

        wait_cnt = 0;
        while ((checked_cnt < n_packets) && (wait_cnt < DRAIN_LIMIT)) begin
            @(posedge clk);
            wait_cnt++;
        end
        repeat (4) @(posedge clk);  // Catch any stray pulse.
        @(negedge clk);
        timed_out = (checked_cnt < n_packets);

        $display("Checked %0d of %0d packets, %0d errors", checked_cnt, n_packets, error_cnt);
        if (timed_out) begin
            $display("Timed out waiting: results are missing for %0d packets",
                     n_packets - checked_cnt);
        end
        if (timed_out || (error_cnt != 0) || (checked_cnt != n_packets)) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

/* files.f */
hw/alu_pkg.sv
hw/issue_decode.sv
hw/simple_alu.sv
hw/exec_result.sv
hw/exec_lane_top.sv
sim/exec_lane_checker.sv
sim/tb_exec_lane.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute lane testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f files.f --top-module tb_exec_lane -o tb_exec_lane

./obj_dir/tb_exec_lane > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
